/* dv/lsTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsTb;

   localparam int MemDepthLog2 = lsPkg::MemAddrW;
   localparam int ByteAddrW = MemDepthLog2 + 2;
   localparam int Depth = 2 ** MemDepthLog2;
   localparam int HalfWords = Depth / 2;
   localparam int NumRegOps = 40;
   localparam int NumLsOps = 60;
   localparam int NumHostOps = 60;
   localparam int CmdCount = 31 + 2 * NumRegOps + 4 + 3 * NumLsOps;
   localparam int HostCount = 2 * HalfWords + NumHostOps;
   localparam int WatchdogCycles = (CmdCount + HostCount) * 20;

   logic                    gclk;
   logic                    rstN;
   logic                    cmdStrobe;
   lsPkg::lsOpE             cmdOp;
   lsPkg::lsSizeE           cmdSize;
   logic [4:0]              cmdRd;
   logic [4:0]              cmdRa;
   logic [4:0]              cmdRb;
   logic [ByteAddrW-1:0]    cmdAddr;
   logic [31:0]             cmdResult;
   logic [31:2]             cmdPcLink;
   logic                    cmdDone;
   logic [31:0]             regA;
   logic [31:0]             regB;
   logic                    hostStrobe;
   logic                    hostWe;
   logic [MemDepthLog2-1:0] hostAddr;
   logic [31:0]             hostWdata;
   logic                    hostValid;
   logic [31:0]             hostRdata;

   // reference model
   logic [31:0] modelRegs [32];
   logic [31:0] modelMem [Depth];
   bit          hostWritten [Depth];

   lsTop #(.MemDepthLog2(MemDepthLog2)) DUT (
      .gclk (gclk), .rstN (rstN),
      .cmdStrobe (cmdStrobe), .cmdOp (cmdOp), .cmdSize (cmdSize),
      .cmdRd (cmdRd), .cmdRa (cmdRa), .cmdRb (cmdRb), .cmdAddr (cmdAddr),
      .cmdResult (cmdResult), .cmdPcLink (cmdPcLink),
      .cmdDone (cmdDone), .regA (regA), .regB (regB),
      .hostStrobe (hostStrobe), .hostWe (hostWe), .hostAddr (hostAddr),
      .hostWdata (hostWdata), .hostValid (hostValid), .hostRdata (hostRdata)
   );

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;
   end

   initial begin
      repeat (WatchdogCycles) @(posedge gclk);
      $display("timeout: the run did not finish within %0d cycles", WatchdogCycles);
      $display("Something failed");
      $fatal(1);
   end

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] want);
      if (got !== want) begin
         $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, want);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   function automatic lsPkg::lsSizeE randSize();
      case ($urandom_range(0, 2))
         0:       return lsPkg::sizeByte;
         1:       return lsPkg::sizeHalf;
         default: return lsPkg::sizeWord;
      endcase
   endfunction

   function automatic void setReg(input logic [4:0] rd, input logic [31:0] val);
      if (rd != 5'd0) begin
         modelRegs[rd] = val;
      end
   endfunction

   // lane placement follows the down-aligned address
   function automatic void storeToModel(input logic [ByteAddrW-1:0] addr,
                                        input lsPkg::lsSizeE size, input logic [31:0] data);
      int w;
      w = int'(addr[ByteAddrW-1:2]);
      case (size)
         lsPkg::sizeByte: modelMem[w][addr[1:0]*8 +: 8] = data[7:0];
         lsPkg::sizeHalf: modelMem[w][addr[1]*16 +: 16] = data[15:0];
         default:         modelMem[w] = data;
      endcase
   endfunction

   function automatic logic [31:0] loadFromModel(input logic [ByteAddrW-1:0] addr,
                                                 input lsPkg::lsSizeE size);
      logic [31:0] word;
      word = modelMem[int'(addr[ByteAddrW-1:2])];
      case (size)
         lsPkg::sizeByte: return {24'd0, word[addr[1:0]*8 +: 8]};
         lsPkg::sizeHalf: return {16'd0, word[addr[1]*16 +: 16]};
         default:         return word;
      endcase
   endfunction

   task automatic issueCmd(input lsPkg::lsOpE op, input lsPkg::lsSizeE size,
                           input logic [4:0] rd, input logic [4:0] ra, input logic [4:0] rb,
                           input logic [ByteAddrW-1:0] addr, input logic [31:0] result,
                           input logic [29:0] pcLink);
      @(posedge gclk);
      cmdStrobe <= 1'b1;
      cmdOp     <= op;
      cmdSize   <= size;
      cmdRd     <= rd;
      cmdRa     <= ra;
      cmdRb     <= rb;
      cmdAddr   <= addr;
      cmdResult <= result;
      cmdPcLink <= pcLink;
      @(posedge gclk);
      cmdStrobe <= 1'b0;
      @(negedge gclk);
      while (!cmdDone) @(negedge gclk);
   endtask

   task automatic writeReg(input logic [4:0] rd, input bit link);
      logic [31:0] res;
      logic [29:0] pc;
      res = $urandom();
      pc = 30'($urandom());
      issueCmd(link ? lsPkg::opLink : lsPkg::opResult, lsPkg::sizeWord, rd, 5'd0, 5'd0,
               '0, res, pc);
      setReg(rd, link ? {pc, 2'b00} : res);
   endtask

   task automatic readRegs(input logic [4:0] ra, input logic [4:0] rb);
      issueCmd(lsPkg::opRead, lsPkg::sizeWord, 5'd0, ra, rb, '0, '0, '0);
      checkValue("regA", regA, modelRegs[ra]);
      checkValue("regB", regB, modelRegs[rb]);
   endtask

   task automatic hostIssue(input bit we, input int addr, input logic [31:0] data);
      @(posedge gclk);
      hostStrobe <= 1'b1;
      hostWe     <= we;
      hostAddr   <= MemDepthLog2'(addr);
      hostWdata  <= data;
      @(posedge gclk);
      hostStrobe <= 1'b0;
      @(negedge gclk);
      while (!hostValid) @(negedge gclk);
   endtask

   task automatic hostWriteWord(input int addr, input logic [31:0] data);
      hostIssue(1'b1, addr, data);
      modelMem[addr] = data;
      hostWritten[addr] = 1'b1;
   endtask

   task automatic hostReadWord(input int addr);
      hostIssue(1'b0, addr, '0);
      checkValue("hostRdata", hostRdata, modelMem[addr]);
   endtask

   // stores, loads and an immediate read-back, lower half only
   task automatic loadStoreTraffic();
      logic [4:0]           rs;
      logic [4:0]           rd;
      logic [ByteAddrW-1:0] stAddr;
      logic [ByteAddrW-1:0] ldAddr;
      lsPkg::lsSizeE        stSize;
      lsPkg::lsSizeE        ldSize;
      for (int n = 0; n < NumLsOps; n++) begin
         rs = 5'($urandom_range(0, 31));
         rd = 5'($urandom_range(1, 31));
         stAddr = ByteAddrW'($urandom_range(0, HalfWords * 4 - 1));
         ldAddr = ByteAddrW'($urandom_range(0, HalfWords * 4 - 1));
         if ($urandom_range(0, 1) == 1) begin
            ldAddr = {stAddr[ByteAddrW-1:2], 2'($urandom())};
         end
         stSize = randSize();
         ldSize = randSize();
         issueCmd(lsPkg::opStore, stSize, rs, 5'd0, 5'd0, stAddr, '0, '0);
         storeToModel(stAddr, stSize, modelRegs[rs]);
         issueCmd(lsPkg::opLoad, ldSize, rd, 5'd0, 5'd0, ldAddr, '0, '0);
         setReg(rd, loadFromModel(ldAddr, ldSize));
         readRegs(rd, rs);
         repeat ($urandom_range(0, 3)) @(posedge gclk);
      end
   endtask

   // host words in the upper half, read only once written
   task automatic hostTraffic();
      int addr;
      for (int n = 0; n < NumHostOps; n++) begin
         addr = HalfWords + int'($urandom_range(0, HalfWords - 1));
         if (!hostWritten[addr] || $urandom_range(0, 1) == 1) begin
            hostWriteWord(addr, $urandom());
         end else begin
            hostReadWord(addr);
         end
         repeat ($urandom_range(0, 3)) @(posedge gclk);
      end
   endtask

   initial begin
      logic [4:0] rdSel;
      void'($urandom(32'h66caef27));
      rstN = 1'b0;
      cmdStrobe = 1'b0;
      cmdOp = lsPkg::opResult;
      cmdSize = lsPkg::sizeWord;
      cmdRd = '0;
      cmdRa = '0;
      cmdRb = '0;
      cmdAddr = '0;
      cmdResult = '0;
      cmdPcLink = '0;
      hostStrobe = 1'b0;
      hostWe = 1'b0;
      hostAddr = '0;
      hostWdata = '0;
      for (int i = 0; i < 32; i++) modelRegs[i] = '0;
      for (int i = 0; i < Depth; i++) modelMem[i] = '0;
      repeat (2) @(posedge gclk);
      rstN <= 1'b1;
      // lower half preloaded through the host port
      for (int i = 0; i < HalfWords; i++) hostWriteWord(i, $urandom());
      for (int r = 1; r < 32; r++) writeReg(5'(r), 1'b0);
      for (int n = 0; n < NumRegOps; n++) begin
         rdSel = 5'($urandom_range(0, 31));
         writeReg(rdSel, $urandom_range(0, 1) == 1);
         readRegs(rdSel, 5'($urandom_range(0, 31)));
      end
      // R0 stays zero
      writeReg(5'd0, 1'b0);
      readRegs(5'd0, 5'd0);
      writeReg(5'd0, 1'b1);
      readRegs(5'd0, 5'd0);
      fork
         loadStoreTraffic();
         hostTraffic();
      join
      // byte enables seen through the host side
      for (int i = 0; i < HalfWords; i++) hostReadWord(i);
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

/* dv/memArbiter_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiterProperties (
   input wire logic gclk,
   input wire logic rstN,
   input wire logic lsReq,
   input wire logic lsWe,
   input wire logic hostWe,
   input wire logic lsGnt,
   input wire logic hostGnt,
   input wire logic lsRvalid,
   input wire logic hostRvalid
);

   // one owner per cycle
   grantOneHot: assert property (@(posedge gclk) disable iff (!rstN)
      !(lsGnt && hostGnt))
      else $error("both peers granted in the same cycle");

   // load/store side has fixed priority
   hostYields: assert property (@(posedge gclk) disable iff (!rstN)
      !(hostGnt && lsReq))
      else $error("host granted while load/store requests");

   // read data comes back to the peer that issued the read, one cycle later
   lsReadResp: assert property (@(posedge gclk) disable iff (!rstN)
      lsRvalid |-> $past(lsGnt && !lsWe))
      else $error("load/store rvalid without a granted read");

   hostReadResp: assert property (@(posedge gclk) disable iff (!rstN)
      hostRvalid |-> $past(hostGnt && !hostWe))
      else $error("host rvalid without a granted read");

endmodule

bind memArbiter memArbiterProperties uProps (
   .gclk       (gclk),
   .rstN       (rstN),
   .lsReq      (lsBus.req),
   .lsWe       (lsBus.we),
   .hostWe     (hostBus.we),
   .lsGnt      (lsBus.gnt),
   .hostGnt    (hostBus.gnt),
   .lsRvalid   (lsBus.rvalid),
   .hostRvalid (hostBus.rvalid)
);

`default_nettype wire

/* files.f */
hw/lsPkg.sv
hw/memBusIf.sv
hw/regFile.sv
hw/loadStoreUnit.sv
hw/hostPort.sv
hw/memArbiter.sv
hw/dataMem.sv
hw/lsTop.sv
dv/memArbiter_properties.sv
dv/lsTb.sv

/* hw/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
   parameter int MemDepthLog2 = lsPkg::MemAddrW
) (
   input  wire logic                    gclk,

   input  wire logic                    we,
   input  wire logic [MemDepthLog2-1:0] addr,
   input  wire logic [lsPkg::DataW-1:0] wdata,
   input  wire logic [lsPkg::BeW-1:0]   be,
   output      logic [lsPkg::DataW-1:0] rdata
);

   localparam int Depth = 2 ** MemDepthLog2;

   logic [lsPkg::DataW-1:0] mem [Depth];

   // per-lane write, read data registered
   always_ff @(posedge gclk) begin
      if (we) begin
         for (int i = 0; i < lsPkg::BeW; i++) begin
            if (be[i]) begin
               mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
            end
         end
      end
      rdata <= mem[addr];
   end

endmodule

`default_nettype wire

/* hw/hostPort.sv */
`timescale 1ns/1ps
`default_nettype none

module hostPort #(
   parameter int MemDepthLog2 = lsPkg::MemAddrW
) (
   input  wire logic                    gclk,
   input  wire logic                    rstN,

   input  wire logic                    hostStrobe,
   input  wire logic                    hostWe,
   input  wire logic [MemDepthLog2-1:0] hostAddr,
   input  wire logic [lsPkg::DataW-1:0] hostWdata,
   output      logic                    hostValid,
   output      logic [lsPkg::DataW-1:0] hostRdata,

   memBusIf.peer                        memBus
);

   logic                    pending;
   logic                    weQ;
   logic [MemDepthLog2-1:0] addrQ;
   logic [lsPkg::DataW-1:0] wdataQ;

   // host always moves whole words
   assign memBus.req   = pending;
   assign memBus.we    = weQ;
   assign memBus.addr  = addrQ;
   assign memBus.wdata = wdataQ;
   assign memBus.be    = '1;

   always_ff @(posedge gclk) begin
      if (!rstN) begin
         pending   <= 1'b0;
         hostValid <= 1'b0;
      end else begin
         hostValid <= (pending && memBus.gnt && weQ) || memBus.rvalid;
         if (hostStrobe) begin
            pending <= 1'b1;
         end else if (memBus.gnt) begin
            pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (hostStrobe) begin
         weQ    <= hostWe;
         addrQ  <= hostAddr;
         wdataQ <= hostWdata;
      end
      if (memBus.rvalid) begin
         hostRdata <= memBus.rdata;
      end
   end

endmodule

`default_nettype wire

/* hw/loadStoreUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit #(
   parameter int MemDepthLog2 = lsPkg::MemAddrW
) (
   input  wire logic                       gclk,
   input  wire logic                       rstN,

   input  wire logic                       cmdStrobe,
   input  wire lsPkg::lsOpE                cmdOp,
   input  wire lsPkg::lsSizeE              cmdSize,
   input  wire logic [lsPkg::RegAddrW-1:0] cmdRd,
   input  wire logic [lsPkg::RegAddrW-1:0] cmdRa,
   input  wire logic [lsPkg::RegAddrW-1:0] cmdRb,
   input  wire logic [MemDepthLog2+1:0]    cmdAddr,
   input  wire logic [lsPkg::DataW-1:0]    cmdResult,
   input  wire logic [lsPkg::DataW-1:2]    cmdPcLink,
   output      logic                       cmdDone,
   output      logic [lsPkg::DataW-1:0]    regA,
   output      logic [lsPkg::DataW-1:0]    regB,

   memBusIf.peer                           memBus
);

   // sequencer state
   logic reqPend;
   logic loadWait;
   logic loadWrite;

   // latched memory command
   logic                       storeQ;
   lsPkg::lsSizeE              sizeQ;
   logic [1:0]                 laneQ;
   logic [MemDepthLog2-1:0]    wordAddrQ;
   logic [lsPkg::RegAddrW-1:0] rdQ;
   logic [lsPkg::DataW-1:0]    loadData;

   logic                       wrEn;
   logic [lsPkg::RegAddrW-1:0] wrAddr;
   logic [lsPkg::DataW-1:0]    wrData;
   logic [lsPkg::DataW-1:0]    rdDataA;
   logic [lsPkg::DataW-1:0]    rdDataB;
   logic [lsPkg::DataW-1:0]    rdDataD;

   lsPkg::laneWordU            loadLane;
   lsPkg::laneWordU            storeLane;
   logic [lsPkg::DataW-1:0]    loadSized;
   logic                       directWr;

   // result and link go straight in at the sampling edge
   assign directWr = cmdStrobe &&
                     (cmdOp == lsPkg::opResult || cmdOp == lsPkg::opLink);

   assign wrEn   = directWr || loadWrite;
   assign wrAddr = loadWrite ? rdQ : cmdRd;

   // write-data select
   always_comb begin
      if (loadWrite) begin
         wrData = loadData;
      end else if (cmdOp == lsPkg::opLink) begin
         wrData = {cmdPcLink, 2'b00};
      end else begin
         wrData = cmdResult;
      end
   end

   regFile uRegFile (
      .gclk    (gclk),
      .rstN    (rstN),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData),
      .rdAddrA (cmdRa),
      .rdAddrB (cmdRb),
      .rdAddrD (rdQ),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .rdDataD (rdDataD)
   );

   // load sizer, lane picked from the low address bits
   always_comb begin
      loadLane.word = memBus.rdata;
      case (sizeQ)
         lsPkg::sizeByte: loadSized = {24'd0, loadLane.bytes[laneQ]};
         lsPkg::sizeHalf: loadSized = {16'd0, loadLane.halves[laneQ[1]]};
         default:         loadSized = loadLane.word;
      endcase
   end

   // store sizer, replicate and enable the addressed lanes
   always_comb begin
      case (sizeQ)
         lsPkg::sizeByte: begin
            storeLane.bytes = {4{rdDataD[7:0]}};
            memBus.be = 4'b0001 << laneQ;
         end
         lsPkg::sizeHalf: begin
            storeLane.halves = {2{rdDataD[15:0]}};
            memBus.be = laneQ[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            storeLane.word = rdDataD;
            memBus.be = 4'b1111;
         end
      endcase
   end

   assign memBus.req   = reqPend;
   assign memBus.we    = storeQ;
   assign memBus.addr  = wordAddrQ;
   assign memBus.wdata = storeLane.word;

   always_ff @(posedge gclk) begin
      if (!rstN) begin
         reqPend   <= 1'b0;
         loadWait  <= 1'b0;
         loadWrite <= 1'b0;
         cmdDone   <= 1'b0;
      end else begin
         cmdDone   <= 1'b0;
         loadWrite <= 1'b0;
         if (cmdStrobe) begin
            if (cmdOp == lsPkg::opLoad || cmdOp == lsPkg::opStore) begin
               reqPend <= 1'b1;
            end else begin
               cmdDone <= 1'b1;
            end
         end
         // stores finish at acceptance, loads wait for data
         if (reqPend && memBus.gnt) begin
            reqPend <= 1'b0;
            if (storeQ) begin
               cmdDone <= 1'b1;
            end else begin
               loadWait <= 1'b1;
            end
         end
         if (loadWait && memBus.rvalid) begin
            loadWait  <= 1'b0;
            loadWrite <= 1'b1;
            cmdDone   <= 1'b1;
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (cmdStrobe) begin
         storeQ    <= (cmdOp == lsPkg::opStore);
         sizeQ     <= cmdSize;
         laneQ     <= cmdAddr[1:0];
         wordAddrQ <= cmdAddr[MemDepthLog2+1:2];
         rdQ       <= cmdRd;
      end
      if (cmdStrobe && cmdOp == lsPkg::opRead) begin
         regA <= rdDataA;
         regB <= rdDataB;
      end
      if (loadWait && memBus.rvalid) begin
         loadData <= loadSized;
      end
   end

endmodule

`default_nettype wire

/* hw/lsPkg.sv */
`default_nettype none

package lsPkg;

   // datapath widths
   localparam int DataW = 32;
   localparam int BeW = DataW / 8;
   localparam int RegAddrW = 5;

   // default data memory depth in words, as log2
   localparam int MemAddrW = 8;

   // command op
   typedef enum logic [2:0] {
      opResult = 3'd0,
      opLink   = 3'd1,
      opLoad   = 3'd2,
      opStore  = 3'd3,
      opRead   = 3'd4
   } lsOpE;

   // access size
   typedef enum logic [1:0] {
      sizeByte = 2'd0,
      sizeHalf = 2'd1,
      sizeWord = 2'd2
   } lsSizeE;

   // one memory word seen as byte lanes, halfword lanes or whole
   typedef union packed {
      logic [3:0][7:0]  bytes;
      logic [1:0][15:0] halves;
      logic [31:0]      word;
   } laneWordU;

endpackage

`default_nettype wire

/* hw/lsTop.sv */
`timescale 1ns/1ps
`default_nettype none

module lsTop #(
   parameter int MemDepthLog2 = lsPkg::MemAddrW
) (
   input  wire logic                       gclk,
   input  wire logic                       rstN,

   input  wire logic                       cmdStrobe,
   input  wire lsPkg::lsOpE                cmdOp,
   input  wire lsPkg::lsSizeE              cmdSize,
   input  wire logic [lsPkg::RegAddrW-1:0] cmdRd,
   input  wire logic [lsPkg::RegAddrW-1:0] cmdRa,
   input  wire logic [lsPkg::RegAddrW-1:0] cmdRb,
   input  wire logic [MemDepthLog2+1:0]    cmdAddr,
   input  wire logic [lsPkg::DataW-1:0]    cmdResult,
   input  wire logic [lsPkg::DataW-1:2]    cmdPcLink,
   output      logic                       cmdDone,
   output      logic [lsPkg::DataW-1:0]    regA,
   output      logic [lsPkg::DataW-1:0]    regB,

   input  wire logic                       hostStrobe,
   input  wire logic                       hostWe,
   input  wire logic [MemDepthLog2-1:0]    hostAddr,
   input  wire logic [lsPkg::DataW-1:0]    hostWdata,
   output      logic                       hostValid,
   output      logic [lsPkg::DataW-1:0]    hostRdata
);

   memBusIf #(.MemDepthLog2(MemDepthLog2)) lsBus ();
   memBusIf #(.MemDepthLog2(MemDepthLog2)) hostBus ();

   logic                    memWe;
   logic [MemDepthLog2-1:0] memAddr;
   logic [lsPkg::DataW-1:0] memWdata;
   logic [lsPkg::BeW-1:0]   memBe;
   logic [lsPkg::DataW-1:0] memRdata;

   loadStoreUnit #(.MemDepthLog2(MemDepthLog2)) uLoadStore (
      .gclk      (gclk),
      .rstN      (rstN),
      .cmdStrobe (cmdStrobe),
      .cmdOp     (cmdOp),
      .cmdSize   (cmdSize),
      .cmdRd     (cmdRd),
      .cmdRa     (cmdRa),
      .cmdRb     (cmdRb),
      .cmdAddr   (cmdAddr),
      .cmdResult (cmdResult),
      .cmdPcLink (cmdPcLink),
      .cmdDone   (cmdDone),
      .regA      (regA),
      .regB      (regB),
      .memBus    (lsBus.peer)
   );

   hostPort #(.MemDepthLog2(MemDepthLog2)) uHostPort (
      .gclk       (gclk),
      .rstN       (rstN),
      .hostStrobe (hostStrobe),
      .hostWe     (hostWe),
      .hostAddr   (hostAddr),
      .hostWdata  (hostWdata),
      .hostValid  (hostValid),
      .hostRdata  (hostRdata),
      .memBus     (hostBus.peer)
   );

   memArbiter #(.MemDepthLog2(MemDepthLog2)) uArbiter (
      .gclk     (gclk),
      .rstN     (rstN),
      .lsBus    (lsBus.arbiter),
      .hostBus  (hostBus.arbiter),
      .memWe    (memWe),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memBe    (memBe),
      .memRdata (memRdata)
   );

   dataMem #(.MemDepthLog2(MemDepthLog2)) uDataMem (
      .gclk  (gclk),
      .we    (memWe),
      .addr  (memAddr),
      .wdata (memWdata),
      .be    (memBe),
      .rdata (memRdata)
   );

endmodule

`default_nettype wire

/* hw/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter #(
   parameter int MemDepthLog2 = lsPkg::MemAddrW
) (
   input  wire logic                    gclk,
   input  wire logic                    rstN,

   memBusIf.arbiter                     lsBus,
   memBusIf.arbiter                     hostBus,

   output      logic                    memWe,
   output      logic [MemDepthLog2-1:0] memAddr,
   output      logic [lsPkg::DataW-1:0] memWdata,
   output      logic [lsPkg::BeW-1:0]   memBe,
   input  wire logic [lsPkg::DataW-1:0] memRdata
);

   logic lsGnt;
   logic hostGnt;

   // read response owner, valid one cycle after a granted read
   logic rdPending;
   logic rdOwnerHost;

   // load/store side always wins
   assign lsGnt   = lsBus.req;
   assign hostGnt = hostBus.req && !lsBus.req;

   assign lsBus.gnt   = lsGnt;
   assign hostBus.gnt = hostGnt;

   assign memWe    = (lsGnt && lsBus.we) || (hostGnt && hostBus.we);
   assign memAddr  = lsGnt ? lsBus.addr  : hostBus.addr;
   assign memWdata = lsGnt ? lsBus.wdata : hostBus.wdata;
   assign memBe    = lsGnt ? lsBus.be    : hostBus.be;

   always_ff @(posedge gclk) begin
      if (!rstN) begin
         rdPending   <= 1'b0;
         rdOwnerHost <= 1'b0;
      end else begin
         rdPending   <= (lsGnt && !lsBus.we) || (hostGnt && !hostBus.we);
         rdOwnerHost <= hostGnt;
      end
   end

   // both peers see the same data, only the owner gets rvalid
   assign lsBus.rdata    = memRdata;
   assign hostBus.rdata  = memRdata;
   assign lsBus.rvalid   = rdPending && !rdOwnerHost;
   assign hostBus.rvalid = rdPending && rdOwnerHost;

endmodule

`default_nettype wire

/* hw/memBusIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface memBusIf #(
   parameter int MemDepthLog2 = lsPkg::MemAddrW
) ();

   logic                    req;
   logic                    we;
   logic [MemDepthLog2-1:0] addr;
   logic [lsPkg::DataW-1:0] wdata;
   logic [lsPkg::BeW-1:0]   be;
   logic                    gnt;
   logic [lsPkg::DataW-1:0] rdata;
   logic                    rvalid;

   // requesting side
   modport peer (
      output req, we, addr, wdata, be,
      input  gnt, rdata, rvalid
   );

   // granting side
   modport arbiter (
      input  req, we, addr, wdata, be,
      output gnt, rdata, rvalid
   );

endinterface

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  wire logic                       gclk,
   input  wire logic                       rstN,

   input  wire logic                       wrEn,
   input  wire logic [lsPkg::RegAddrW-1:0] wrAddr,
   input  wire logic [lsPkg::DataW-1:0]    wrData,

   input  wire logic [lsPkg::RegAddrW-1:0] rdAddrA,
   input  wire logic [lsPkg::RegAddrW-1:0] rdAddrB,
   input  wire logic [lsPkg::RegAddrW-1:0] rdAddrD,
   output      logic [lsPkg::DataW-1:0]    rdDataA,
   output      logic [lsPkg::DataW-1:0]    rdDataB,
   output      logic [lsPkg::DataW-1:0]    rdDataD
);

   localparam int NumRegs = 2 ** lsPkg::RegAddrW;

   logic [lsPkg::DataW-1:0] regs [NumRegs];

   // R0 is never a write target
   logic wrLive;

   assign wrLive = wrEn && (wrAddr != '0);

   // one read port, with bypass of the write in flight
   function automatic logic [lsPkg::DataW-1:0] readPort(
      input logic [lsPkg::RegAddrW-1:0] addr
   );
      logic hit;
      hit = wrLive && (addr == wrAddr);
      if (hit) begin
         return wrData;
      end
      return regs[addr];
   endfunction

   // R0 cleared here and never written again
   always_ff @(posedge gclk) begin
      if (!rstN) begin
         regs[0] <= '0;
      end else if (wrLive) begin
         regs[wrAddr] <= wrData;
      end
   end

   // A and B go to the command outputs, D feeds the store sizer
   always_comb begin
      rdDataA = readPort(rdAddrA);
      rdDataB = readPort(rdAddrB);
      rdDataD = readPort(rdAddrD);
   end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the lsTb simulation with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module lsTb -f files.f -o lsTbSim &&
./obj_dir/lsTbSim ||
exit 1
